// ==== decodePkg.sv ====
// Shared types and constants for the decode stage, imported by every RTL block and the testbench
package decodePkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0]  regIdx_t;

    // Opcodes live in instr[15:11]
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opJr    = 5'b00101,
        opJal   = 5'b00110,
        opJalr  = 5'b00111,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opBgez  = 5'b01111,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opSlbi  = 5'b10010,
        opStu   = 5'b10011,
        opLbi   = 5'b11000,
        opRtype = 5'b11011
    } opcode_e;

    typedef enum logic [2:0] {
        aluAdd       = 3'd0,
        aluSub       = 3'd1,
        aluAnd       = 3'd2,
        aluXor       = 3'd3,
        aluPassB     = 3'd4,
        aluShiftLoad = 3'd5
    } aluOp_e;

    // branchCond is {valid, cond[1:0]}
    localparam int BranchValid = 2;
    localparam logic [1:0] CondEqz = 2'b00;
    localparam logic [1:0] CondNez = 2'b01;
    localparam logic [1:0] CondLtz = 2'b10;
    localparam logic [1:0] CondGez = 2'b11;

    // Bit positions inside jumpCtl
    localparam int JumpIsJump  = 2;
    localparam int JumpRegBase = 1;
    localparam int JumpLink    = 0;

    // Return address register for JAL and JALR
    localparam regIdx_t LinkReg = 3'd7;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrc;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        logic       halt;
        logic       illegal;
        aluOp_e     aluOp;
        logic [2:0] branchCond;
        logic [2:0] jumpCtl;
    } ctrl_t;

    // Result a later stage will write, already qualified by its NOP status
    typedef struct packed {
        logic    valid;
        regIdx_t rd;
        word_t   data;
    } fwdSrc_t;

    typedef struct packed {
        logic    en;
        regIdx_t rd;
        word_t   data;
    } wrBack_t;

endpackage

// ==== regFileBypass.sv ====
// Eight-entry register file with two read ports and write-to-read bypass, used by the decode stage
`timescale 1ns/1ps

module regFileBypass import decodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regIdx_t rsSel,
    input  regIdx_t rtSel,
    input  wrBack_t wrBack,
    output word_t   rsData,
    output word_t   rtData
);

    word_t regs [8];

    logic rsHit;
    logic rtHit;

    // Write port, all entries cleared on reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrBack.en) begin
            regs[wrBack.rd] <= wrBack.data;
        end
    end

    // A write in flight to the selected register wins over the stored value
    assign rsHit = wrBack.en && (wrBack.rd == rsSel);
    assign rtHit = wrBack.en && (wrBack.rd == rtSel);

    always_comb begin
        if (rsHit) begin
            rsData = wrBack.data;
        end else begin
            rsData = regs[rsSel];
        end
    end

    always_comb begin
        if (rtHit) begin
            rtData = wrBack.data;
        end else begin
            rtData = regs[rtSel];
        end
    end

endmodule

// ==== controlDecoder.sv ====
// Opcode decoder producing datapath controls and the destination register for the decode stage
`timescale 1ns/1ps

module controlDecoder import decodePkg::*; (
    input  word_t   instr,
    output ctrl_t   ctrl,
    output regIdx_t rdOut
);

    opcode_e opcode;
    aluOp_e  rtypeOp;

    assign opcode = opcode_e'(instr[15:11]);

    // Function bits select the R-type operation
    always_comb begin
        case (instr[1:0])
            2'b00:   rtypeOp = aluAdd;
            2'b01:   rtypeOp = aluSub;
            2'b10:   rtypeOp = aluAnd;
            default: rtypeOp = aluXor;
        endcase
    end

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        case (opcode)
            opHalt: begin
                ctrl.halt = 1'b1;
            end
            opNop: begin
                // Nothing to do
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            opSubi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluSub;
            end
            opSt: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opLd: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opStu: begin
                // Store, then write the updated address back to Rs
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opLbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluPassB;
            end
            opSlbi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluShiftLoad;
            end
            opRtype: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rtypeOp;
            end
            opBeqz: ctrl.branchCond = {1'b1, CondEqz};
            opBnez: ctrl.branchCond = {1'b1, CondNez};
            opBltz: ctrl.branchCond = {1'b1, CondLtz};
            opBgez: ctrl.branchCond = {1'b1, CondGez};
            opJ: begin
                ctrl.jumpCtl[JumpIsJump] = 1'b1;
            end
            opJr: begin
                ctrl.jumpCtl[JumpIsJump]  = 1'b1;
                ctrl.jumpCtl[JumpRegBase] = 1'b1;
            end
            opJal: begin
                ctrl.regWrite           = 1'b1;
                ctrl.jumpCtl[JumpIsJump] = 1'b1;
                ctrl.jumpCtl[JumpLink]   = 1'b1;
            end
            opJalr: begin
                ctrl.regWrite             = 1'b1;
                ctrl.jumpCtl[JumpIsJump]  = 1'b1;
                ctrl.jumpCtl[JumpRegBase] = 1'b1;
                ctrl.jumpCtl[JumpLink]    = 1'b1;
            end
            default: begin
                // Unknown opcode behaves as a NOP
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    // Destination index per format
    always_comb begin
        case (opcode)
            opRtype:                  rdOut = instr[4:2];
            opLbi, opSlbi, opStu:     rdOut = instr[10:8];
            opJal, opJalr:            rdOut = LinkReg;
            default:                  rdOut = instr[7:5];
        endcase
    end

endmodule

// ==== immExtend.sv ====
// Immediate field selection and extension by instruction format for the decode stage
`timescale 1ns/1ps

module immExtend import decodePkg::*; (
    input  word_t instr,
    output word_t immVal
);

    typedef enum logic [2:0] {
        fmtNone,
        fmtImm5,
        fmtImm8S,
        fmtImm8Z,
        fmtImm11
    } immFmt_e;

    immFmt_e fmt;

    always_comb begin
        case (opcode_e'(instr[15:11]))
            opAddi, opSubi, opLd, opSt, opStu:   fmt = fmtImm5;
            opLbi, opBeqz, opBnez, opBltz, opBgez,
            opJr, opJalr:                        fmt = fmtImm8S;
            opSlbi:                              fmt = fmtImm8Z;
            opJ, opJal:                          fmt = fmtImm11;
            default:                             fmt = fmtNone;
        endcase
    end

    always_comb begin
        case (fmt)
            fmtImm5:  immVal = {{11{instr[4]}}, instr[4:0]};
            fmtImm8S: immVal = {{8{instr[7]}}, instr[7:0]};
            fmtImm8Z: immVal = {8'h00, instr[7:0]};
            fmtImm11: immVal = {{5{instr[10]}}, instr[10:0]};
            default:  immVal = '0;
        endcase
    end

endmodule

// ==== branchResolve.sv ====
// Branch and jump resolution in decode with forwarded base operand, target adder and PC select
`timescale 1ns/1ps

module branchResolve import decodePkg::*; (
    input  word_t      pcInc,
    input  regIdx_t    rsSel,
    input  word_t      rsData,
    input  word_t      immVal,
    input  logic [2:0] branchCond,
    input  logic [2:0] jumpCtl,
    input  fwdSrc_t    exFwd,
    input  fwdSrc_t    memFwd,
    output word_t      pcNew,
    output logic       pcSrc
);

    word_t baseOp;
    word_t addA;
    logic  exHit;
    logic  memHit;
    logic  condHolds;
    logic  branchTaken;
    logic  jumpReq;

    assign exHit  = exFwd.valid && (exFwd.rd == rsSel);
    assign memHit = memFwd.valid && (memFwd.rd == rsSel);

    // Execute result is younger, so it takes priority over memory
    always_comb begin
        if (exHit) begin
            baseOp = exFwd.data;
        end else if (memHit) begin
            baseOp = memFwd.data;
        end else begin
            baseOp = rsData;
        end
    end

    always_comb begin
        case (branchCond[1:0])
            CondEqz: condHolds = (baseOp == '0);
            CondNez: condHolds = (baseOp != '0);
            CondLtz: condHolds = baseOp[15];
            CondGez: condHolds = ~baseOp[15];
            default: condHolds = 1'b0;
        endcase
    end

    assign branchTaken = branchCond[BranchValid] & condHolds;

    assign jumpReq = jumpCtl[JumpIsJump];

    // JR and JALR add to the register, everything else to the incremented PC
    assign addA  = jumpCtl[JumpRegBase] ? baseOp : pcInc;
    assign pcNew = addA + immVal;

    // Also serves as the flush request for fetch
    assign pcSrc = jumpReq | branchTaken;

endmodule

// ==== decodeStage.sv ====
// Decode stage top, joining register file, control decoder, immediate unit and branch unit
`timescale 1ns/1ps

module decodeStage import decodePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  word_t   instr,
    input  word_t   pcInc,
    input  wrBack_t wrBack,
    input  fwdSrc_t exFwd,
    input  fwdSrc_t memFwd,
    output ctrl_t   ctrl,
    output regIdx_t rdOut,
    output word_t   rsData,
    output word_t   rtData,
    output word_t   immVal,
    output word_t   pcNew,
    output logic    pcSrc
);

    regIdx_t rsSel;
    regIdx_t rtSel;

    // Fixed source register fields
    assign rsSel = instr[10:8];
    assign rtSel = instr[7:5];

    regFileBypass u_regFileBypass (
        .clk    (clk),
        .rstN   (rstN),
        .rsSel  (rsSel),
        .rtSel  (rtSel),
        .wrBack (wrBack),
        .rsData (rsData),
        .rtData (rtData)
    );

    controlDecoder u_controlDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .rdOut (rdOut)
    );

    immExtend u_immExtend (
        .instr  (instr),
        .immVal (immVal)
    );

    branchResolve u_branchResolve (
        .pcInc      (pcInc),
        .rsSel      (rsSel),
        .rsData     (rsData),
        .immVal     (immVal),
        .branchCond (ctrl.branchCond),
        .jumpCtl    (ctrl.jumpCtl),
        .exFwd      (exFwd),
        .memFwd     (memFwd),
        .pcNew      (pcNew),
        .pcSrc      (pcSrc)
    );

endmodule

// ==== tbClock.sv ====
// Free-running testbench clock with an 8 ns period, instantiated by the decode stage testbench
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

endmodule

// ==== decodeStage_sva.sv ====
// Concurrent checks bound into the decode stage, comparing its outputs with the testbench model
`timescale 1ns/1ps

module decodeStage_sva import decodePkg::*; (
    input logic    clk,
    input logic    rstN,
    input ctrl_t   ctrl,
    input regIdx_t rdOut,
    input word_t   rsData,
    input word_t   rtData,
    input word_t   immVal,
    input word_t   pcNew,
    input logic    pcSrc
);

    int failCount = 0;

    ctrlOk: assert property (@(posedge clk) disable iff (!rstN) ctrl == decodeStage_tb.expCtrl)
        else begin
            failCount++;
            $error("mismatch at %0t: ctrl %h expected %h", $time, $sampled(ctrl),
                   $sampled(decodeStage_tb.expCtrl));
        end

    rdOk: assert property (@(posedge clk) disable iff (!rstN) rdOut == decodeStage_tb.expRd)
        else begin
            failCount++;
            $error("mismatch at %0t: rdOut %0d expected %0d", $time, $sampled(rdOut),
                   $sampled(decodeStage_tb.expRd));
        end

    immOk: assert property (@(posedge clk) disable iff (!rstN) immVal == decodeStage_tb.expImm)
        else begin
            failCount++;
            $error("mismatch at %0t: immVal %h expected %h", $time, $sampled(immVal),
                   $sampled(decodeStage_tb.expImm));
        end

    // Both read ports in one check
    operandOk: assert property (@(posedge clk) disable iff (!rstN)
        {rsData, rtData} == {decodeStage_tb.expRs, decodeStage_tb.expRt})
        else begin
            failCount++;
            $error("mismatch at %0t: rs/rt %h/%h expected %h/%h", $time, $sampled(rsData),
                   $sampled(rtData), $sampled(decodeStage_tb.expRs), $sampled(decodeStage_tb.expRt));
        end

    // Target only matters for branches and jumps
    pcOk: assert property (@(posedge clk) disable iff (!rstN)
        pcSrc == decodeStage_tb.expPcSrc
        && (!decodeStage_tb.expPcValid || pcNew == decodeStage_tb.expPcNew))
        else begin
            failCount++;
            $error("mismatch at %0t: pcSrc %b pcNew %h expected %b %h", $time, $sampled(pcSrc),
                   $sampled(pcNew), $sampled(decodeStage_tb.expPcSrc),
                   $sampled(decodeStage_tb.expPcNew));
        end

endmodule

// ==== decodeStage_tb.sv ====
// Decode stage testbench with a shadow register model, directed and random stimulus and reports
`timescale 1ns/1ps

module decodeStage_tb import decodePkg::*; ();

    localparam int ResetCycles = 8;
    localparam int MaxCycles   = 2000;

    logic    clk;
    logic    rstN;
    word_t   instr;
    word_t   pcInc;
    wrBack_t wrBack;
    fwdSrc_t exFwd;
    fwdSrc_t memFwd;
    ctrl_t   ctrl;
    regIdx_t rdOut;
    word_t   rsData;
    word_t   rtData;
    word_t   immVal;
    word_t   pcNew;
    logic    pcSrc;

    // Expected outputs, read by the bound checker
    ctrl_t   expCtrl;
    regIdx_t expRd;
    word_t   expRs;
    word_t   expRt;
    word_t   expImm;
    word_t   expPcNew;
    logic    expPcSrc;
    logic    expPcValid;

    word_t   shadowRegs [8];
    wrBack_t curWr;
    int      testsRun;
    int      testsFailed;
    int      failMark;
    opcode_e legalOps [18] = '{opHalt, opNop, opAddi, opSubi, opSt, opLd, opStu, opLbi, opSlbi,
                               opRtype, opBeqz, opBnez, opBltz, opBgez, opJ, opJr, opJal, opJalr};

    tbClock u_tbClock (.clk(clk));

    decodeStage u_decodeStage (.*);

    bind decodeStage decodeStage_sva u_sva (.*);

    // Expected controls straight from the opcode table
    function automatic ctrl_t refCtrl(word_t ins);
        ctrl_t      c;
        logic [4:0] op;
        logic       isJump;
        op = ins[15:11];
        isJump = (op[4:2] == 3'b001);
        c = '0;
        c.illegal  = !(op inside {opHalt, opNop, opAddi, opSubi, opSt, opLd, opStu, opLbi,
                                  opSlbi, opRtype, opBeqz, opBnez, opBltz, opBgez, opJ, opJr,
                                  opJal, opJalr});
        c.halt     = (op == opHalt);
        c.regWrite = op inside {opAddi, opSubi, opLd, opStu, opLbi, opSlbi, opRtype,
                                opJal, opJalr};
        c.aluSrc   = op inside {opAddi, opSubi, opSt, opLd, opStu, opLbi, opSlbi};
        c.memWrite = op inside {opSt, opStu};
        c.memRead  = (op == opLd);
        c.memToReg = (op == opLd);
        case (op)
            opSubi:  c.aluOp = aluSub;
            opLbi:   c.aluOp = aluPassB;
            opSlbi:  c.aluOp = aluShiftLoad;
            // Function codes run ADD, SUB, AND, XOR
            opRtype: c.aluOp = aluOp_e'({1'b0, ins[1:0]});
            default: c.aluOp = aluAdd;
        endcase
        // Branch opcodes carry their condition in the low two bits
        c.branchCond = (op[4:2] == 3'b011) ? {1'b1, op[1:0]} : 3'b000;
        c.jumpCtl    = {isJump, isJump & op[0], isJump & op[1]};
        return c;
    endfunction

    function automatic regIdx_t refRd(word_t ins);
        logic [4:0] op;
        op = ins[15:11];
        if (op == opRtype) begin
            return ins[4:2];
        end else if (op inside {opLbi, opSlbi, opStu}) begin
            return ins[10:8];
        end else if (op inside {opJal, opJalr}) begin
            return LinkReg;
        end
        return ins[7:5];
    endfunction

    function automatic word_t refImm(word_t ins);
        logic [4:0] op;
        op = ins[15:11];
        if (op inside {opAddi, opSubi, opLd, opSt, opStu}) begin
            return {{11{ins[4]}}, ins[4:0]};
        end else if (op inside {opLbi, opBeqz, opBnez, opBltz, opBgez, opJr, opJalr}) begin
            return {{8{ins[7]}}, ins[7:0]};
        end else if (op == opSlbi) begin
            return {8'h00, ins[7:0]};
        end else if (op inside {opJ, opJal}) begin
            return {{5{ins[10]}}, ins[10:0]};
        end
        return '0;
    endfunction

    function automatic logic condHolds(logic [1:0] cond, word_t v);
        case (cond)
            CondEqz: return v == '0;
            CondNez: return v != '0;
            CondLtz: return v[15];
            default: return !v[15];
        endcase
    endfunction

    // Register read as decode sees it, write in flight included
    function automatic word_t readReg(regIdx_t idx);
        if (curWr.en && curWr.rd == idx) begin
            return curWr.data;
        end
        return shadowRegs[idx];
    endfunction

    // Zero and negative values show up often enough to hit every branch outcome
    function automatic word_t pickValue();
        case ($urandom_range(3))
            0: return '0;
            1: return 16'h8000 | word_t'($urandom);
            default: return word_t'($urandom);
        endcase
    endfunction

    task automatic drive(input word_t ins, input wrBack_t wb, input fwdSrc_t ex,
                         input fwdSrc_t mem);
        ctrl_t c;
        word_t base;
        word_t pc;
        @(posedge clk);
        // DUT commits the previous write at this edge
        if (curWr.en) begin
            shadowRegs[curWr.rd] = curWr.data;
        end
        curWr = wb;
        c = refCtrl(ins);
        pc = word_t'($urandom);
        base = readReg(ins[10:8]);
        if (ex.valid && ex.rd == ins[10:8]) begin
            base = ex.data;
        end else if (mem.valid && mem.rd == ins[10:8]) begin
            base = mem.data;
        end
        instr      <= ins;
        pcInc      <= pc;
        wrBack     <= wb;
        exFwd      <= ex;
        memFwd     <= mem;
        expCtrl    <= c;
        expRd      <= refRd(ins);
        expRs      <= readReg(ins[10:8]);
        expRt      <= readReg(ins[7:5]);
        expImm     <= refImm(ins);
        expPcValid <= c.branchCond[BranchValid] | c.jumpCtl[JumpIsJump];
        expPcNew   <= (c.jumpCtl[JumpRegBase] ? base : pc) + refImm(ins);
        expPcSrc   <= c.jumpCtl[JumpIsJump]
                      | (c.branchCond[BranchValid] & condHolds(c.branchCond[1:0], base));
    endtask

    // Modes cycle through register file, memory, execute, and both with execute winning
    // Sources that must lose carry either a low valid or a different register index
    task automatic controlFlow(input opcode_e op, input int trials);
        word_t   ins;
        wrBack_t wb;
        fwdSrc_t ex;
        fwdSrc_t mem;
        regIdx_t other;
        int      mode;
        for (int i = 0; i < trials; i++) begin
            ins   = {op, 11'($urandom)};
            mode  = i % 4;
            other = ins[10:8] + 3'd1;
            wb    = '{en: mode == 0, rd: ins[10:8], data: pickValue()};
            ex    = '{valid: mode != 0, rd: (mode == 1) ? other : ins[10:8],
                      data: pickValue()};
            mem   = '{valid: mode != 2, rd: (mode == 0) ? other : ins[10:8],
                      data: pickValue()};
            drive(ins, wb, ex, mem);
        end
    endtask

    task automatic finishTest(input string name);
        int errs;
        @(posedge clk);
        #1;
        errs = u_decodeStage.u_sva.failCount - failMark;
        failMark = u_decodeStage.u_sva.failCount;
        testsRun++;
        if (errs != 0) begin
            testsFailed++;
        end
        $display("[%0t] test %0d %s: %s (%0d errors)", $time, testsRun, name,
                 errs == 0 ? "ok" : "FAILED", errs);
    endtask

    initial begin
        for (int i = 0; i < MaxCycles; i++) begin
            @(posedge clk);
        end
        $display("Timeout: stimulus did not finish within %0d cycles", MaxCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        wrBack_t wb;
        void'($urandom(32'hf166deca));
        rstN       = 1'b0;
        instr      = {opNop, 11'd0};
        pcInc      = '0;
        wrBack     = '0;
        exFwd      = '0;
        memFwd     = '0;
        curWr      = '0;
        shadowRegs = '{default: '0};
        {expCtrl, expRd, expRs, expRt, expImm, expPcNew, expPcSrc, expPcValid} = '0;
        testsRun    = 0;
        testsFailed = 0;
        failMark    = 0;
        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge clk);
        end
        rstN <= 1'b1;

        for (int i = 0; i < 8; i++) begin
            drive({opNop, 3'(i), 3'(7 - i), 5'd0}, '0, '0, '0);
        end
        finishTest("reset state");

        for (int i = 0; i < 8; i++) begin
            wb = '{en: 1'b1, rd: 3'(i), data: word_t'($urandom)};
            drive({opNop, 3'(i), 3'(i), 5'd0}, wb, '0, '0);
            drive({opNop, 3'(i), 3'((i + 5) % 8), 5'd0}, '0, '0, '0);
        end
        finishTest("write then read");

        foreach (legalOps[k]) begin
            drive({legalOps[k], 11'($urandom)}, '0, '0, '0);
        end
        // Every R-type function code at least once
        for (int f = 0; f < 4; f++) begin
            drive({opRtype, 9'($urandom), 2'(f)}, '0, '0, '0);
        end
        for (int i = 0; i < 40; i++) begin
            wb = '{en: 1'($urandom), rd: 3'($urandom), data: word_t'($urandom)};
            drive(word_t'($urandom), wb, '0, '0);
        end
        finishTest("control and destination");

        foreach (legalOps[k]) begin
            for (int i = 0; i < 4; i++) begin
                drive({legalOps[k], 11'($urandom)}, '0, '0, '0);
            end
        end
        finishTest("immediate formats");

        controlFlow(opBeqz, 16);
        controlFlow(opBnez, 16);
        controlFlow(opBltz, 16);
        controlFlow(opBgez, 16);
        finishTest("branches");

        controlFlow(opJ, 16);
        controlFlow(opJal, 16);
        controlFlow(opJr, 16);
        controlFlow(opJalr, 16);
        finishTest("jumps");

        $display("Tests run %0d, failed %0d, assertion failures %0d", testsRun, testsFailed,
                 u_decodeStage.u_sva.failCount);
        if (testsFailed == 0 && u_decodeStage.u_sva.failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
decodePkg.sv
regFileBypass.sv
controlDecoder.sv
immExtend.sv
branchResolve.sv
decodeStage.sv
tbClock.sv
decodeStage_sva.sv
decodeStage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decodeStage_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

run: compile
	./$(OBJDIR)/$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
